// ==== bench/tb_dtw.sv ====
`include "dtw_defs.svh"

module tb_dtw;
    timeunit 1ns;
    timeprecision 1ps;

    logic               clk;
    logic               nrst = 1'b0;
    logic               i_valid = 1'b0;
    logic               i_bt_end = 1'b0;
    dtw_pkg::sample_t   i_r = '0;
    dtw_pkg::sample_t   i_t = '0;
    logic               o_ready;
    logic               o_dc_ena;
    logic               o_bt_ena;
    dtw_pkg::mem_addr_t o_addr;
    logic               o_wr;
    dtw_pkg::sample_t   o_r;
    dtw_pkg::sample_t   o_t;
    dtw_pkg::src_t      o_tsrc;
    dtw_pkg::src_t      o_rsrc;
    dtw_pkg::sel_t      o_sel0;
    dtw_pkg::sel_t      o_sel1;
    dtw_pkg::sel_t      o_sel2;

    // reference bookkeeping, each value lags the DUT by one edge
    logic [31:0]        rng = 32'd13;
    int                 dc_cnt = 0;
    int                 bt_cnt = 0;
    int                 bt_len_exp = 0;
    dtw_pkg::mem_addr_t next_idx = 10'd1;
    dtw_pkg::mem_addr_t addr_prev = '0;
    dtw_pkg::sample_t   t_prev = '0;
    dtw_pkg::sample_t   r_prev = '0;
    logic [77:0]        sched_prev = '0;
    int                 fails [1:6] = '{default: 0};
    bit                 timed_out = 1'b0;

    // idle flags, then clean sources and all-ones selects
    localparam logic [81:0] reset_vec = {4'b1000, 24'd0, {54{1'b1}}};
    logic [81:0] state_vec;
    logic [77:0] sched_vec;

    assign state_vec = {o_ready, o_dc_ena, o_bt_ena, o_wr, o_tsrc, o_rsrc, o_sel0, o_sel1, o_sel2};
    assign sched_vec = {o_tsrc, o_rsrc, o_sel0, o_sel1, o_sel2};

    dtw_ctrl uut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic bit has_code3(input dtw_pkg::src_t f);
        bit hit;
        hit = 1'b0;
        for (int c = 0; c < `DTW_CELLS; c++) begin
            if (f[2*c +: 2] == 2'd3) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "reset_state";
            2: return "job_timing";
            3: return "dc_addresses";
            4: return "bt_writes";
            5: return "sample_paths";
            default: return "cell_schedule";
        endcase
    endfunction

    function automatic void value_wrong(input int id, input logic [127:0] exp_v,
                                        input logic [127:0] act_v);
        $display("ERR %s expected %0h actual %0h", test_name(id), exp_v, act_v);
        fails[id]++;
    endfunction

    function automatic void check_failed(input int id, input string what);
        $display("%s: %s", test_name(id), what);
        fails[id]++;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        rng        <= xorshift(rng);
        i_r        <= i_r + 30'd1;
        i_t        <= rng[29:0];
        dc_cnt     <= o_dc_ena ? dc_cnt + 1 : 0;
        bt_cnt     <= o_bt_ena ? bt_cnt + 1 : 0;
        addr_prev  <= o_addr;
        t_prev     <= i_t;
        r_prev     <= o_r;
        sched_prev <= sched_vec;
        if (!o_dc_ena) begin
            next_idx <= 10'd1;
        end else if (o_addr != '0) begin
            next_idx <= next_idx + 10'd1;
        end
    end

    a_reset_state: assert property (@(posedge clk) $rose(nrst) |-> state_vec == reset_vec)
        else value_wrong(1, 128'(reset_vec), 128'($sampled(state_vec)));

    a_job_start: assert property (@(posedge clk) disable iff (!nrst)
        $rose(o_dc_ena) |-> $past(i_valid && o_ready))
        else check_failed(2, "DC phase started without an accepted i_valid");
    a_one_phase: assert property (@(posedge clk) disable iff (!nrst)
        $onehot({o_ready, o_dc_ena, o_bt_ena}))
        else check_failed(2, "o_ready, o_dc_ena and o_bt_ena are not one-hot");
    a_dc_len: assert property (@(posedge clk) disable iff (!nrst)
        (!o_dc_ena && dc_cnt > 0) |-> dc_cnt == `DTW_DC_END + 1)
        else value_wrong(2, 128'(`DTW_DC_END + 1), 128'($sampled(dc_cnt)));
    a_dc_to_bt: assert property (@(posedge clk) disable iff (!nrst)
        (!o_dc_ena && dc_cnt > 0) |-> o_bt_ena)
        else check_failed(2, "back-trace did not follow the DC phase");
    a_bt_len: assert property (@(posedge clk) disable iff (!nrst)
        (!o_bt_ena && bt_cnt > 0) |-> bt_cnt == bt_len_exp)
        else value_wrong(2, 128'($sampled(bt_len_exp)), 128'($sampled(bt_cnt)));
    a_bt_done: assert property (@(posedge clk) disable iff (!nrst)
        $past(o_bt_ena && i_bt_end) |-> o_ready)
        else check_failed(2, "o_ready did not return one cycle after i_bt_end");

    a_dc_addr: assert property (@(posedge clk) disable iff (!nrst)
        (o_dc_ena && o_addr != '0) |-> o_addr == next_idx)
        else value_wrong(3, 128'($sampled(next_idx)), 128'($sampled(o_addr)));
    // indices 1 to 19 give a final count of 20
    a_dc_count: assert property (@(posedge clk) disable iff (!nrst)
        (!o_dc_ena && dc_cnt > 0) |-> next_idx == 10'd20)
        else value_wrong(3, 128'(20), 128'($sampled(next_idx)));
    a_dc_no_wr: assert property (@(posedge clk) disable iff (!nrst) o_dc_ena |-> !o_wr)
        else check_failed(3, "o_wr went high during the DC phase");

    a_bt_wr: assert property (@(posedge clk) disable iff (!nrst) o_bt_ena |-> o_wr)
        else check_failed(4, "o_wr was low during back-trace");
    a_bt_first: assert property (@(posedge clk) disable iff (!nrst)
        (o_bt_ena && bt_cnt == 0) |-> o_addr == 10'(`DTW_BT_START))
        else value_wrong(4, 128'(`DTW_BT_START), 128'($sampled(o_addr)));
    a_bt_next: assert property (@(posedge clk) disable iff (!nrst)
        (o_bt_ena && bt_cnt > 0) |-> o_addr == addr_prev + 10'd1)
        else value_wrong(4, 128'($sampled(addr_prev) + 10'd1), 128'($sampled(o_addr)));
    a_valid_ignored: assert property (@(posedge clk) disable iff (!nrst)
        $past(i_valid && !o_ready && !i_bt_end) |-> !o_ready)
        else check_failed(4, "i_valid during a job ended the job");

    a_tmpl_delay: assert property (@(posedge clk) disable iff (!nrst) o_t == t_prev)
        else value_wrong(5, 128'($sampled(t_prev)), 128'($sampled(o_t)));
    // a picked word is 2 to depth+1 stamps old when it shows on o_r
    a_ref_stamp: assert property (@(posedge clk) disable iff (!nrst)
        (o_dc_ena && o_r != r_prev) |->
        (i_r - o_r) >= 30'd2 && (i_r - o_r) <= 30'(`DTW_REF_DEPTH + 1))
        else check_failed(5, $sformatf("o_r took stamp %0d, too far from stamp %0d",
                                       $sampled(o_r), $sampled(i_r)));

    a_src_code: assert property (@(posedge clk) disable iff (!nrst)
        !has_code3(o_tsrc) && !has_code3(o_rsrc))
        else check_failed(6, $sformatf("source code 3 seen, tsrc %0h rsrc %0h",
                                       $sampled(o_tsrc), $sampled(o_rsrc)));
    a_idle_hold: assert property (@(posedge clk) disable iff (!nrst)
        ($past(o_ready) && $past(o_ready, 2) && $past(nrst, 2)) |-> sched_vec == sched_prev)
        else value_wrong(6, 128'($sampled(sched_prev)), 128'($sampled(sched_vec)));

    task automatic wait_bt_phase();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!o_bt_ena && n < 100);
        if (!o_bt_ena) begin
            $display("timeout: back-trace did not start within 100 cycles");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!o_ready && n < 50);
        if (!o_ready) begin
            $display("timeout: o_ready did not return within 50 cycles");
            timed_out = 1'b1;
        end
    endtask

    // one job with a back-trace of bt_len cycles, bt_len of 2 or more
    task automatic run_job(input int bt_len, input bit poke_valid);
        bt_len_exp <= bt_len;
        i_valid    <= 1'b1;
        @(posedge clk);
        i_valid <= 1'b0;
        if (poke_valid) begin
            repeat (10) @(posedge clk);
            i_valid <= 1'b1;
            @(posedge clk);
            i_valid <= 1'b0;
        end
        wait_bt_phase();
        if (!timed_out) begin
            i_valid <= poke_valid;
            repeat (bt_len - 2) begin
                @(posedge clk);
                i_valid <= 1'b0;
            end
            i_bt_end <= 1'b1;
            @(posedge clk);
            i_bt_end <= 1'b0;
            i_valid  <= 1'b0;
            wait_idle();
        end
    endtask

    task automatic finish_test(input int id);
        $display("%s: %s, %0d failed checks", test_name(id),
                 (fails[id] == 0) ? "pass" : "fail", fails[id]);
    endtask

    initial begin
        int total;
        int passed;
        total  = 0;
        passed = 0;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        repeat (4) @(posedge clk);
        finish_test(1);
        run_job(3, 1'b0);
        if (!timed_out) begin
            repeat (4) @(posedge clk);
            run_job(9, 1'b1);
        end
        repeat (4) @(posedge clk);
        for (int id = 2; id <= 6; id++) begin
            finish_test(id);
        end
        for (int id = 1; id <= 6; id++) begin
            total = total + fails[id];
            if (fails[id] == 0) begin
                passed++;
            end
        end
        $display("tests 6, passed %0d, failed checks %0d, timeout %0d", passed, total, timed_out);
        if (total == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the DTW controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_dtw -o tb_dtw
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_dtw > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$log"; then
    exit 0
fi
exit 1

// ==== sim.f ====
+incdir+verilog
verilog/dtw_pkg.sv
verilog/dtw_phase_fsm.sv
verilog/dtw_cell_schedule.sv
verilog/dtw_ref_window.sv
verilog/dtw_tmpl_fetch.sv
verilog/dtw_ctrl.sv
bench/tb_dtw.sv

// ==== verilog/dtw_cell_schedule.sv ====
`include "dtw_defs.svh"

module dtw_cell_schedule (
    input  logic           clk,
    input  logic           nrst,
    input  dtw_pkg::step_t i_step,
    output dtw_pkg::src_t  o_tsrc,
    output dtw_pkg::src_t  o_rsrc,
    output dtw_pkg::sel_t  o_sel0,
    output dtw_pkg::sel_t  o_sel1,
    output dtw_pkg::sel_t  o_sel2
);

    // cells touched by the current row, cell 0 in bit 0
    logic [`DTW_CELLS-1:0]   row_mask;
    // one hex digit per cell, {tsrc, rsrc}
    logic [4*`DTW_CELLS-1:0] row_src;
    dtw_pkg::sel_t           row_sel0;
    dtw_pkg::sel_t           row_sel1;
    dtw_pkg::sel_t           row_sel2;

    // wavefront table, cell 5 is the leftmost digit of each field
    always_comb begin
        row_mask = '0;
        row_src  = '0;
        row_sel0 = '0;
        row_sel1 = '0;
        row_sel2 = '0;
        case (i_step)
            6'd0: begin
                row_mask = 6'b001000;
                row_src  = 24'h00a000;
                row_sel0 = 18'o007000;
                row_sel1 = 18'o006000;
                row_sel2 = 18'o006000;
            end
            6'd1: begin
                row_mask = 6'b001100;
                row_src  = 24'h002900;
                row_sel0 = 18'o006600;
                row_sel1 = 18'o006200;
                row_sel2 = 18'o002600;
            end
            6'd2, 6'd36, 6'd38: begin
                row_mask = 6'b001000;
                row_src  = 24'h004000;
                row_sel0 = 18'o002000;
                row_sel1 = 18'o002000;
                row_sel2 = 18'o003000;
            end
            6'd3, 6'd37: begin
                row_mask = 6'b001100;
                row_src  = 24'h002900;
                row_sel0 = 18'o002300;
                row_sel1 = 18'o006200;
                row_sel2 = 18'o002600;
            end
            6'd4: begin
                row_mask = 6'b011100;
                row_src  = 24'h064800;
                row_sel0 = 18'o062600;
                row_sel1 = 18'o062300;
                row_sel2 = 18'o023600;
            end
            6'd5, 6'd33, 6'd35: begin
                row_mask = 6'b001100;
                row_src  = 24'h001100;
                row_sel0 = 18'o002300;
                row_sel1 = 18'o001200;
                row_sel2 = 18'o002300;
            end
            6'd6, 6'd34: begin
                row_mask = 6'b011100;
                row_src  = 24'h064800;
                row_sel0 = 18'o012300;
                row_sel1 = 18'o062300;
                row_sel2 = 18'o023600;
            end
            6'd7: begin
                row_mask = 6'b011110;
                row_src  = 24'h021190;
                row_sel0 = 18'o062360;
                row_sel1 = 18'o061230;
                row_sel2 = 18'o012360;
            end
            6'd8, 6'd10, 6'd28, 6'd30, 6'd32: begin
                row_mask = 6'b011100;
                row_src  = 24'h044400;
                row_sel0 = 18'o012300;
                row_sel1 = 18'o012300;
                row_sel2 = 18'o023400;
            end
            6'd9, 6'd11, 6'd29, 6'd31: begin
                row_mask = 6'b011110;
                row_src  = 24'h021190;
                row_sel0 = 18'o012340;
                row_sel1 = 18'o061230;
                row_sel2 = 18'o012360;
            end
            6'd12: begin
                row_mask = 6'b111110;
                row_src  = 24'h644480;
                row_sel0 = 18'o612360;
                row_sel1 = 18'o612340;
                row_sel2 = 18'o123460;
            end
            6'd13, 6'd25, 6'd27: begin
                row_mask = 6'b011110;
                row_src  = 24'h011110;
                row_sel0 = 18'o012340;
                row_sel1 = 18'o001230;
                row_sel2 = 18'o012340;
            end
            6'd14, 6'd26: begin
                row_mask = 6'b111110;
                row_src  = 24'h644480;
                row_sel0 = 18'o012340;
                row_sel1 = 18'o612340;
                row_sel2 = 18'o123460;
            end
            6'd15: begin
                row_mask = 6'b111111;
                row_src  = 24'h211119;
                row_sel0 = 18'o612346;
                row_sel1 = 18'o601234;
                row_sel2 = 18'o012346;
            end
            // steady state, the full array alternates between two rows
            6'd16, 6'd18, 6'd20, 6'd22, 6'd24: begin
                row_mask = 6'b111110;
                row_src  = 24'h444440;
                row_sel0 = 18'o012340;
                row_sel1 = 18'o012340;
                row_sel2 = 18'o123450;
            end
            6'd17, 6'd19, 6'd21, 6'd23: begin
                row_mask = 6'b111111;
                row_src  = 24'h211119;
                row_sel0 = 18'o012345;
                row_sel1 = 18'o601234;
                row_sel2 = 18'o012346;
            end
            default: row_mask = '0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            o_tsrc <= '0;
            o_rsrc <= '0;
            o_sel0 <= '1;
            o_sel1 <= '1;
            o_sel2 <= '1;
        end else begin
            for (int c = 0; c < `DTW_CELLS; c++) begin
                if (row_mask[c]) begin
                    o_tsrc[2*c +: 2] <= row_src[4*c+2 +: 2];
                    o_rsrc[2*c +: 2] <= row_src[4*c +: 2];
                    o_sel0[3*c +: 3] <= row_sel0[3*c +: 3];
                    o_sel1[3*c +: 3] <= row_sel1[3*c +: 3];
                    o_sel2[3*c +: 3] <= row_sel2[3*c +: 3];
                end
            end
        end
    end

    // code 3 has no operand behind it in the cell mux
    for (genvar c = 0; c < `DTW_CELLS; c++) begin : g_src_chk
        a_src_code: assert property (@(posedge clk) disable iff (!nrst)
            (o_tsrc[2*c +: 2] != 2'd3) && (o_rsrc[2*c +: 2] != 2'd3));
    end

endmodule

// ==== verilog/dtw_ctrl.sv ====
module dtw_ctrl (
    input  logic               clk,
    input  logic               nrst,
    input  logic               i_valid,
    input  logic               i_bt_end,
    input  dtw_pkg::sample_t   i_r,
    input  dtw_pkg::sample_t   i_t,
    output logic               o_ready,
    output logic               o_dc_ena,
    output logic               o_bt_ena,
    output dtw_pkg::mem_addr_t o_addr,
    output logic               o_wr,
    output dtw_pkg::sample_t   o_r,
    output dtw_pkg::sample_t   o_t,
    output dtw_pkg::src_t      o_tsrc,
    output dtw_pkg::src_t      o_rsrc,
    output dtw_pkg::sel_t      o_sel0,
    output dtw_pkg::sel_t      o_sel1,
    output dtw_pkg::sel_t      o_sel2
);

    dtw_pkg::phase_t phase;
    dtw_pkg::step_t  step;

    dtw_phase_fsm u_fsm (
        .clk      (clk),
        .nrst     (nrst),
        .i_valid  (i_valid),
        .i_bt_end (i_bt_end),
        .o_phase  (phase),
        .o_step   (step),
        .o_ready  (o_ready),
        .o_dc_ena (o_dc_ena),
        .o_bt_ena (o_bt_ena)
    );

    dtw_cell_schedule u_sched (
        .clk    (clk),
        .nrst   (nrst),
        .i_step (step),
        .o_tsrc (o_tsrc),
        .o_rsrc (o_rsrc),
        .o_sel0 (o_sel0),
        .o_sel1 (o_sel1),
        .o_sel2 (o_sel2)
    );

    dtw_ref_window u_rwin (
        .clk    (clk),
        .nrst   (nrst),
        .i_step (step),
        .i_r    (i_r),
        .o_r    (o_r)
    );

    dtw_tmpl_fetch u_tfetch (
        .clk     (clk),
        .i_phase (phase),
        .i_step  (step),
        .i_t     (i_t),
        .o_t     (o_t),
        .o_addr  (o_addr),
        .o_wr    (o_wr)
    );

endmodule

// ==== verilog/dtw_defs.svh ====
`ifndef DTW_DEFS_SVH
`define DTW_DEFS_SVH

// last step of the distance-computation phase
`define DTW_DC_END 40

// step value loaded when back-trace starts
`define DTW_BT_START 20

// reference samples held in the shift window
`define DTW_REF_DEPTH 20

`define DTW_SAMPLE_W 30
`define DTW_ADDR_W 10

// array columns driven by the cell schedule
`define DTW_CELLS 6

`endif

// ==== verilog/dtw_phase_fsm.sv ====
`include "dtw_defs.svh"

module dtw_phase_fsm (
    input  logic            clk,
    input  logic            nrst,
    input  logic            i_valid,
    input  logic            i_bt_end,
    output dtw_pkg::phase_t o_phase,
    output dtw_pkg::step_t  o_step,
    output logic            o_ready,
    output logic            o_dc_ena,
    output logic            o_bt_ena
);

    dtw_pkg::phase_t phase_nxt;

    always_comb begin
        phase_nxt = o_phase;
        case (o_phase)
            dtw_pkg::PH_IDLE: if (i_valid) phase_nxt = dtw_pkg::PH_DC;
            dtw_pkg::PH_DC: begin
                if (o_step == dtw_pkg::step_t'(`DTW_DC_END)) begin
                    phase_nxt = dtw_pkg::PH_BT;
                end
            end
            dtw_pkg::PH_BT: if (i_bt_end) phase_nxt = dtw_pkg::PH_IDLE;
            default: phase_nxt = dtw_pkg::PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            o_phase <= dtw_pkg::PH_IDLE;
        end else begin
            o_phase <= phase_nxt;
        end
    end

    // step is 0 in idle, so both phases start from a known count
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            o_step <= '0;
        end else if (o_phase == dtw_pkg::PH_IDLE || phase_nxt == dtw_pkg::PH_IDLE) begin
            o_step <= '0;
        end else if (o_phase == dtw_pkg::PH_DC && phase_nxt == dtw_pkg::PH_BT) begin
            o_step <= dtw_pkg::step_t'(`DTW_BT_START);
        end else begin
            o_step <= o_step + 6'd1;
        end
    end

    assign o_ready  = (o_phase == dtw_pkg::PH_IDLE);
    assign o_dc_ena = (o_phase == dtw_pkg::PH_DC);
    assign o_bt_ena = (o_phase == dtw_pkg::PH_BT);

    a_dc_step_bound: assert property (@(posedge clk) disable iff (!nrst)
        (o_phase == dtw_pkg::PH_DC) |-> (o_step <= dtw_pkg::step_t'(`DTW_DC_END)));

endmodule

// ==== verilog/dtw_pkg.sv ====
`include "dtw_defs.svh"

package dtw_pkg;

    typedef enum logic [1:0] {
        PH_IDLE = 2'd0,
        PH_DC   = 2'd1,
        PH_BT   = 2'd2
    } phase_t;

    typedef logic [5:0] step_t;
    typedef logic [`DTW_SAMPLE_W-1:0] sample_t;
    typedef logic [`DTW_ADDR_W-1:0] mem_addr_t;
    typedef logic [4:0] tmpl_idx_t;

    // one 2-bit source code per cell, cell 0 in the low bits
    typedef logic [2*`DTW_CELLS-1:0] src_t;
    // one 3-bit min-select code per cell
    typedef logic [3*`DTW_CELLS-1:0] sel_t;

endpackage

// ==== verilog/dtw_ref_window.sv ====
`include "dtw_defs.svh"

module dtw_ref_window (
    input  logic             clk,
    input  logic             nrst,
    input  dtw_pkg::step_t   i_step,
    input  dtw_pkg::sample_t i_r,
    output dtw_pkg::sample_t o_r
);

    // word k entered k+1 cycles ago
    dtw_pkg::sample_t win [`DTW_REF_DEPTH];

    logic                              pick_en;
    logic [$clog2(`DTW_REF_DEPTH)-1:0] pick_idx;

    always_ff @(posedge clk) begin
        win[0] <= i_r;
        for (int k = 1; k < `DTW_REF_DEPTH; k++) begin
            win[k] <= win[k-1];
        end
    end

    // word the array needs on the step after this one
    always_comb begin
        pick_en  = 1'b1;
        pick_idx = '0;
        case (i_step)
            6'd0, 6'd1:   pick_idx = 5'd0;
            6'd3, 6'd4:   pick_idx = 5'd1;
            6'd6, 6'd7:   pick_idx = 5'd2;
            6'd9:         pick_idx = 5'd3;
            6'd11, 6'd12: pick_idx = 5'd4;
            6'd14, 6'd15: pick_idx = 5'd5;
            6'd17:        pick_idx = 5'd6;
            6'd19:        pick_idx = 5'd7;
            6'd21:        pick_idx = 5'd8;
            6'd23:        pick_idx = 5'd9;
            6'd26:        pick_idx = 5'd11;
            6'd29:        pick_idx = 5'd13;
            6'd31:        pick_idx = 5'd14;
            6'd34:        pick_idx = 5'd16;
            6'd37:        pick_idx = 5'd18;
            default:      pick_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            o_r <= '0;
        end else if (pick_en) begin
            o_r <= win[pick_idx];
        end
    end

endmodule

// ==== verilog/dtw_tmpl_fetch.sv ====
module dtw_tmpl_fetch (
    input  logic               clk,
    input  dtw_pkg::phase_t    i_phase,
    input  dtw_pkg::step_t     i_step,
    input  dtw_pkg::sample_t   i_t,
    output dtw_pkg::sample_t   o_t,
    output dtw_pkg::mem_addr_t o_addr,
    output logic               o_wr
);

    dtw_pkg::tmpl_idx_t tmpl_idx;

    always_ff @(posedge clk) begin
        o_t <= i_t;
    end

    // template word fetched for the next diagonal
    always_comb begin
        tmpl_idx = '0;
        if (i_phase == dtw_pkg::PH_DC) begin
            case (i_step)
                6'd0:    tmpl_idx = 5'd1;
                6'd2:    tmpl_idx = 5'd2;
                6'd3:    tmpl_idx = 5'd3;
                6'd5:    tmpl_idx = 5'd4;
                6'd6:    tmpl_idx = 5'd5;
                6'd8:    tmpl_idx = 5'd6;
                6'd10:   tmpl_idx = 5'd7;
                6'd11:   tmpl_idx = 5'd8;
                6'd13:   tmpl_idx = 5'd9;
                6'd14:   tmpl_idx = 5'd10;
                6'd16:   tmpl_idx = 5'd11;
                6'd18:   tmpl_idx = 5'd12;
                6'd20:   tmpl_idx = 5'd13;
                6'd22:   tmpl_idx = 5'd14;
                6'd25:   tmpl_idx = 5'd15;
                6'd28:   tmpl_idx = 5'd16;
                6'd30:   tmpl_idx = 5'd17;
                6'd33:   tmpl_idx = 5'd18;
                6'd36:   tmpl_idx = 5'd19;
                default: tmpl_idx = '0;
            endcase
        end
    end

    // back-trace writes the path memory at the step address
    assign o_wr   = (i_phase == dtw_pkg::PH_BT);
    assign o_addr = o_wr ? dtw_pkg::mem_addr_t'(i_step) : dtw_pkg::mem_addr_t'(tmpl_idx);

    // path memory writes only open when a DC phase hands over to back-trace
    a_wr_after_dc: assert property (@(posedge clk)
        $rose(o_wr) |-> $past(i_phase) == dtw_pkg::PH_DC);

endmodule
